// File: Makefile
# Verilator build and run of the link testbench

LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module link_tb -f vlog.f

run: compile
	./obj_dir/Vlink_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: dv/link_chk.sv
////////////////////
// Strobe and idle-line assertions for the link modules
// Inputs that a target lacks are tied off where it is bound
////////////////////

`timescale 1ns/1ps

module link_chk (
    input logic clk,
    input logic reset,
    input logic strobe,       // One-cycle pulse to watch
    input logic strobe_flag,  // Only allowed together with strobe
    input logic busy,
    input logic line          // Idles high while not busy
);

    // A strobe lasts a single clock
    a_single_pulse: assert property (
        @(posedge clk) disable iff (reset) strobe |=> !strobe
    ) else $error("strobe high two cycles in a row");

    // No frame in flight means an idle line
    a_line_idle: assert property (
        @(posedge clk) disable iff (reset) !busy |-> line
    ) else $error("line low while not busy");

    a_flag_gated: assert property (
        @(posedge clk) disable iff (reset) strobe_flag |-> strobe
    ) else $error("flag high without its strobe");

endmodule

// File: dv/link_tb.sv
////////////////////
// Testbench for link_top with loopback and a direct line driver
// Frame timing follows LINK_HALF_BIT, results are matched in order
////////////////////

`timescale 1ns/1ps

`include "link_macros.svh"

module link_tb
    import link_pkg::*;
();

    localparam int bit_clks   = 2 * `LINK_HALF_BIT;  // Clocks per bit
    localparam int frame_clks = 11 * bit_clks;
    localparam int wait_limit = 4 * frame_clks;      // Cycles before a wait gives up

    logic                clk;
    logic                reset;
    logic                send;
    logic [nibble_w-1:0] send_nibble;
    logic                busy;
    logic                tx;
    logic                rx_line;
    logic                rx_valid;
    logic [nibble_w-1:0] rx_nibble;
    logic                rx_corrected;
    logic                rx_uncorrectable;
    logic                rx_parity_error;
    logic                loopback;      // tx wired back to rx
    logic                rx_drive;      // Level from the frame driver

    logic [6:0] exp_q[$];               // {parity_error, uncorrectable, corrected, nibble}
    int         exp_count     = 0;
    int         got_count     = 0;
    int         result_errors = 0;      // Compare process
    int         state_errors  = 0;      // Stimulus checks
    int         timeouts      = 0;
    integer     seed;

    tb_clock u_clock (.clk(clk), .reset(reset));

    assign rx_line = loopback ? tx : rx_drive;

    link_top DUT (
        .clk              (clk),
        .reset            (reset),
        .send             (send),
        .send_nibble      (send_nibble),
        .busy             (busy),
        .tx               (tx),
        .rx               (rx_line),
        .rx_valid         (rx_valid),
        .rx_nibble        (rx_nibble),
        .rx_corrected     (rx_corrected),
        .rx_uncorrectable (rx_uncorrectable),
        .rx_parity_error  (rx_parity_error)
    );

    bind uart_rx link_chk u_rx_chk (.clk(clk), .reset(reset), .strobe(done),
        .strobe_flag(parity_error), .busy(1'b0), .line(1'b1));
    bind uart_tx link_chk u_tx_chk (.clk(clk), .reset(reset), .strobe(1'b0),
        .strobe_flag(1'b0), .busy(busy), .line(tx));
    bind secded_codec link_chk u_codec_chk (.clk(clk), .reset(reset), .strobe(valid),
        .strobe_flag(1'b0), .busy(1'b0), .line(1'b1));

    // XOR of the positions of all set bits 7..1
    function automatic logic [2:0] syndrome_of(input logic [7:0] b);
        logic [2:0] s;
        s = 3'd0;
        for (int k = 1; k < 8; k++) begin
            if (b[k]) s = s ^ 3'(k);
        end
        return s;
    endfunction

    function automatic codeword_u encode_ref(input logic [3:0] n);
        codeword_u  cw;
        logic [2:0] s;
        cw.raw  = 8'h00;
        cw.f.d0 = n[0];
        cw.f.d1 = n[1];
        cw.f.d2 = n[2];
        cw.f.d3 = n[3];
        s       = syndrome_of(cw.raw);  // Parity bits cancel the data syndrome
        cw.f.p1 = s[0];
        cw.f.p2 = s[1];
        cw.f.p4 = s[2];
        cw.f.ovr = ^cw.raw[7:1];        // Whole byte even
        return cw;
    endfunction

    // Returns {uncorrectable, corrected, nibble}
    function automatic logic [5:0] decode_ref(input logic [7:0] b);
        codeword_u  cw;
        logic [2:0] s;
        logic       cor;
        logic       unc;
        cw.raw = b;
        s      = syndrome_of(b);
        cor    = 1'b0;
        unc    = 1'b0;
        if (^b) begin
            cor = 1'b1;                             // Single error, maybe the ovr bit
            if (s != 3'd0) cw.raw[s] = ~cw.raw[s];
        end else if (s != 3'd0) begin
            unc = 1'b1;                             // Two errors, data as received
        end
        return {unc, cor, cw.f.d3, cw.f.d2, cw.f.d1, cw.f.d0};
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp, inout int errs);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errs++;
        end
    endtask

    task automatic expect_result(input logic perr, input logic [5:0] flags_nibble);
        exp_q.push_back({perr, flags_nibble});
        exp_count++;
    endtask

    task automatic send_cmd(input logic [3:0] n);
        @(negedge clk);
        send_nibble = n;
        send        = 1'b1;
        @(negedge clk);
        send = 1'b0;
        check_value("busy", 8'(busy), 8'h01, state_errors);  // Frame started
    endtask

    // One frame straight onto rx, bits change on falling edges
    task automatic drive_frame(input logic [7:0] b, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (^b) ^ 1'(`LINK_PARITY_ODD) ^ bad_parity, b, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 11; i++) begin
            rx_drive = bits[i];
            repeat (bit_clks) @(negedge clk);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(negedge clk);
        while (reset === 1'b1 && n < wait_limit) begin
            check_value("tx", 8'(tx), 8'h01, state_errors);
            check_value("busy", 8'(busy), 8'h00, state_errors);
            check_value("rx_valid", 8'(rx_valid), 8'h00, state_errors);
            @(negedge clk);
            n++;
        end
        if (reset === 1'b1) begin
            $display("timeout: reset was never released");
            timeouts++;
        end
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (busy !== 1'b0 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("timeout: busy stayed high after a frame");
            timeouts++;
        end
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (got_count < exp_count && n < wait_limit) begin
            @(posedge clk);  // got_count moves on falling edges
            n++;
        end
        if (got_count < exp_count) begin
            $display("timeout: %0d results expected but %0d received", exp_count, got_count);
            timeouts++;
        end
    endtask

    // Takes each result while rx_valid is high
    always @(negedge clk) begin : compare
        logic [6:0] e;
        if (reset === 1'b0 && rx_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("rx_valid arrived while no result was expected");
                result_errors++;
            end else begin
                e = exp_q.pop_front();
                check_value("rx_nibble", 8'(rx_nibble), 8'(e[3:0]), result_errors);
                check_value("rx_corrected", 8'(rx_corrected), 8'(e[4]), result_errors);
                check_value("rx_uncorrectable", 8'(rx_uncorrectable), 8'(e[5]),
                            result_errors);
                check_value("rx_parity_error", 8'(rx_parity_error), 8'(e[6]), result_errors);
            end
            got_count++;
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [3:0]  n;
        logic [2:0]  a;
        logic [2:0]  b;
        logic [7:0]  bad;
        logic [5:0]  dec;
        codeword_u   cw;
        seed        = 32'hcd44_8532;
        send        = 1'b0;
        send_nibble = 4'h0;
        loopback    = 1'b1;
        rx_drive    = 1'b1;

        wait_reset_release();                       // Reset state
        check_value("tx", 8'(tx), 8'h01, state_errors);
        check_value("busy", 8'(busy), 8'h00, state_errors);
        check_value("rx_valid", 8'(rx_valid), 8'h00, state_errors);

        for (int i = 0; i < 16; i++) begin          // All nibbles in loopback
            n = 4'(i);
            expect_result(1'b0, {2'b00, n});
            send_cmd(n);
            wait_busy_low();
            wait_results();
        end

        @(negedge clk);
        loopback = 1'b0;
        for (int pos = 0; pos < 8; pos++) begin     // One flipped bit
            r  = $random(seed);
            n  = r[3:0];
            cw = encode_ref(n);
            expect_result(1'b0, {2'b01, n});
            drive_frame(cw.raw ^ (8'h01 << pos), 1'b0);
            wait_results();
        end

        for (int i = 0; i < 8; i++) begin           // Two distinct flipped bits
            r   = $random(seed);
            n   = r[3:0];
            a   = r[6:4];
            b   = a + 3'd1 + 3'(r[9:7] % 7);
            cw  = encode_ref(n);
            bad = cw.raw ^ (8'h01 << a) ^ (8'h01 << b);
            dec = decode_ref(bad);
            expect_result(1'b0, {2'b10, dec[3:0]});
            drive_frame(bad, 1'b0);
            wait_results();
        end

        r  = $random(seed);                         // Frame parity
        n  = r[3:0];
        cw = encode_ref(n);
        expect_result(1'b1, {2'b00, n});
        drive_frame(cw.raw, 1'b1);
        wait_results();
        expect_result(1'b0, {2'b00, n});
        drive_frame(cw.raw, 1'b0);
        wait_results();

        @(negedge clk);                             // Send while busy
        loopback = 1'b1;
        r = $random(seed);
        n = r[3:0];
        expect_result(1'b0, {2'b00, n});
        send_cmd(n);
        repeat (3 * bit_clks) @(negedge clk);
        send_cmd(~n);                               // Dropped
        wait_busy_low();
        wait_results();
        repeat (2 * frame_clks) @(negedge clk);     // Room for a stray frame
        check_value("rx_valid count", 8'(got_count), 8'(exp_count), state_errors);

        if (exp_q.size() != 0) begin
            $display("%0d expected results never arrived", exp_q.size());
            timeouts++;
        end
        $display("errors: %0d result mismatches, %0d state mismatches, %0d timeouts",
                 result_errors, state_errors, timeouts);
        if (result_errors == 0 && state_errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: dv/tb_clock.sv
////////////////////
// Testbench clock of 8 ns and a 16-cycle reset
// Reset is released on a falling edge
////////////////////

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);  // 16 rising edges in reset
        @(negedge clk);
        reset <= 1'b0;               // Settles after this edge's reads
    end

endmodule

// File: logic/link_macros.svh
////////////////////
// Link timing and frame parity defaults
// LINK_HALF_BIT counts clocks, so one bit is twice that
// Both ends of a cable must agree on LINK_PARITY_ODD
////////////////////

`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

// Clocks per half bit
// 8 clocks per bit, 88 per 11-bit frame at the default
`define LINK_HALF_BIT 4

// Frame parity sense
// 0 makes data plus parity even, 1 makes it odd
`define LINK_PARITY_ODD 0

`endif

// File: logic/link_pkg.sv
////////////////////
// Shared widths and the received codeword type
// Codeword bit k holds Hamming position k, and bit 0 is overall parity
////////////////////

package link_pkg;

    localparam int nibble_w = 4;  // Command code width
    localparam int byte_w   = 8;  // Codeword and UART payload width

    // One SECDED codeword read either as a plain byte or by field
    typedef union packed {
        logic [byte_w-1:0] raw;   // Byte as it sits on the wire
        struct packed {
            logic d3;             // Position 7
            logic d2;             // Position 6
            logic d1;             // Position 5
            logic p4;             // Position 4
            logic d0;             // Position 3
            logic p2;             // Position 2
            logic p1;             // Position 1
            logic ovr;            // Overall parity, whole byte even
        } f;
    } codeword_u;

endpackage

// File: logic/link_top.sv
////////////////////
// Serial endpoint for SECDED-coded command nibbles
// No back-pressure, so results must be taken during rx_valid
////////////////////

`timescale 1ns/1ps

`include "link_macros.svh"

module link_top
    import link_pkg::*;
#(
    parameter int HALF_BIT = `LINK_HALF_BIT  // Shared by both directions
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                send,             // One-cycle send request
    input  logic [nibble_w-1:0] send_nibble,      // Command to send
    output logic                busy,             // Frame in flight
    output logic                tx,               // Serial line out
    input  logic                rx,               // Serial line in
    output logic                rx_valid,         // One-cycle result strobe
    output logic [nibble_w-1:0] rx_nibble,
    output logic                rx_corrected,
    output logic                rx_uncorrectable,
    output logic                rx_parity_error
);

    logic [byte_w-1:0] tx_byte;         // Encoded codeword
    logic [byte_w-1:0] rx_byte;         // Raw received byte
    logic              rx_done;         // Receiver strobe
    logic              frame_par_err;   // Receiver parity check

    secded_codec u_codec (
        .clk                (clk),
        .reset              (reset),
        .enc_nibble         (send_nibble),
        .enc_byte           (tx_byte),
        .dec_byte           (rx_byte),
        .dec_strobe         (rx_done),
        .frame_parity_error (frame_par_err),
        .nibble             (rx_nibble),
        .valid              (rx_valid),
        .corrected          (rx_corrected),
        .uncorrectable      (rx_uncorrectable),
        .parity_error       (rx_parity_error)
    );

    uart_tx #(.HALF_BIT(HALF_BIT)) u_tx (
        .clk   (clk),
        .reset (reset),
        .send  (send),
        .data  (tx_byte),
        .busy  (busy),
        .tx    (tx)
    );

    uart_rx #(.HALF_BIT(HALF_BIT)) u_rx (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .data         (rx_byte),
        .done         (rx_done),
        .parity_error (frame_par_err)
    );

endmodule

// File: logic/secded_codec.sv
////////////////////
// Hamming(7,4) plus overall parity on a command nibble
// Corrects one flipped bit and flags two, more is undetected
// Decode results are registered and valid for one clock
////////////////////

`timescale 1ns/1ps

module secded_codec
    import link_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [nibble_w-1:0] enc_nibble,          // Nibble to send
    output logic [byte_w-1:0]   enc_byte,            // Codeword to transmitter
    input  logic [byte_w-1:0]   dec_byte,            // Byte from receiver
    input  logic                dec_strobe,          // Receiver done
    input  logic                frame_parity_error,  // Valid with dec_strobe
    output logic [nibble_w-1:0] nibble,              // Decoded command
    output logic                valid,               // One clock after dec_strobe
    output logic                corrected,           // Single error fixed
    output logic                uncorrectable,       // Double error seen
    output logic                parity_error         // Frame parity was wrong
);

    codeword_u         enc_cw;     // Outgoing codeword
    codeword_u         rx_cw;      // Received as is
    codeword_u         fix_cw;     // After single-bit correction
    logic [2:0]        syndrome;   // Hamming position of a single error
    logic              odd_ovr;    // Whole byte parity is odd
    logic [byte_w-1:0] flip_mask;  // Bit to invert, or none

    // Encoder
    always_comb begin
        enc_cw.f.d0  = enc_nibble[0];
        enc_cw.f.d1  = enc_nibble[1];
        enc_cw.f.d2  = enc_nibble[2];
        enc_cw.f.d3  = enc_nibble[3];
        enc_cw.f.p1  = enc_nibble[0] ^ enc_nibble[1] ^ enc_nibble[3];  // Covers 3,5,7
        enc_cw.f.p2  = enc_nibble[0] ^ enc_nibble[2] ^ enc_nibble[3];  // Covers 3,6,7
        enc_cw.f.p4  = enc_nibble[1] ^ enc_nibble[2] ^ enc_nibble[3];  // Covers 5,6,7
        enc_cw.f.ovr = enc_cw.f.p1 ^ enc_cw.f.p2 ^ enc_cw.f.p4 ^ (^enc_nibble);
    end

    assign enc_byte = enc_cw.raw;

    // Decoder
    assign rx_cw.raw   = dec_byte;
    assign syndrome[0] = rx_cw.f.p1 ^ rx_cw.f.d0 ^ rx_cw.f.d1 ^ rx_cw.f.d3;
    assign syndrome[1] = rx_cw.f.p2 ^ rx_cw.f.d0 ^ rx_cw.f.d2 ^ rx_cw.f.d3;
    assign syndrome[2] = rx_cw.f.p4 ^ rx_cw.f.d1 ^ rx_cw.f.d2 ^ rx_cw.f.d3;
    assign odd_ovr     = ^rx_cw.raw;

    // Byte bit k is position k, so the syndrome indexes the byte directly
    assign flip_mask  = ((syndrome != 3'd0) && odd_ovr) ? (byte_w'(1) << syndrome) : '0;
    assign fix_cw.raw = rx_cw.raw ^ flip_mask;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= dec_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_strobe) begin
            nibble        <= {fix_cw.f.d3, fix_cw.f.d2, fix_cw.f.d1, fix_cw.f.d0};
            corrected     <= odd_ovr;                            // Includes flipped ovr bit
            uncorrectable <= (syndrome != 3'd0) && !odd_ovr;     // Data passed as received
            parity_error  <= frame_parity_error;
        end
    end

endmodule

// File: logic/uart_rx.sv
////////////////////
// Samples each bit at its middle after a half-bit start wait
// The stop bit is not checked, so no framing errors
// parity_error is valid only while done is high
////////////////////

`timescale 1ns/1ps

`include "link_macros.svh"

module uart_rx
    import link_pkg::*;
#(
    parameter int HALF_BIT = `LINK_HALF_BIT  // Clocks per half bit
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx,            // Serial line in
    output logic [byte_w-1:0] data,          // Last received byte
    output logic              done,          // One-cycle pulse at mid stop
    output logic              parity_error   // Gated by done
);

    // Receive FSM state codes
    localparam logic [1:0] s_init    = 2'b01;
    localparam logic [1:0] s_idle    = 2'b00;
    localparam logic [1:0] s_start   = 2'b11;
    localparam logic [1:0] s_receive = 2'b10;

    localparam int cnt_w = $clog2(2 * HALF_BIT);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(HALF_BIT - 1);      // Mid start reached
    localparam logic [cnt_w-1:0] bit_last  = cnt_w'(2 * HALF_BIT - 1);  // Next bit middle
    localparam logic [3:0]       stop_idx  = 4'd9;                      // Tenth sample

    logic [1:0]       state;
    logic [cnt_w-1:0] clk_cnt;    // Clocks since last sample point
    logic [3:0]       bit_idx;    // Sample points taken in this frame
    logic [8:0]       shift_reg;  // Parity in bit 8, data below

    // Data plus parity against the configured sense
    assign parity_error = done & ((^{shift_reg[8], data}) ^ 1'(`LINK_PARITY_ODD));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_init;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;                            // Pulse by default off
            case (state)
                s_init: begin
                    clk_cnt   <= '0;
                    bit_idx   <= '0;
                    shift_reg <= '0;
                    state     <= s_idle;             // One cycle before watching rx
                end
                s_idle: begin
                    if (!rx) begin                   // First low sample
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= s_start;
                    end
                end
                s_start: begin
                    if (clk_cnt == half_last) begin
                        clk_cnt <= '0;               // Now at mid start bit
                        state   <= s_receive;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                s_receive: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 4'd1;
                        if (bit_idx == stop_idx) begin
                            data  <= shift_reg[7:0]; // Mid stop bit
                            done  <= 1'b1;
                            state <= s_idle;
                        end else begin
                            shift_reg <= {rx, shift_reg[8:1]};  // LSB first
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= s_init;
            endcase
        end
    end

endmodule

// File: logic/uart_tx.sv
////////////////////
// 11-bit frame of start, 8 data LSB first, parity, stop
// A send while busy is dropped, and there is no queue
////////////////////

`timescale 1ns/1ps

`include "link_macros.svh"

module uart_tx
    import link_pkg::*;
#(
    parameter int HALF_BIT = `LINK_HALF_BIT  // Clocks per half bit
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              send,          // One-cycle request
    input  logic [byte_w-1:0] data,          // Byte to frame
    output logic              busy,          // High for the whole frame
    output logic              tx             // Serial line, idles high
);

    localparam int cnt_w = $clog2(2 * HALF_BIT);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(2 * HALF_BIT - 1);  // Last clock of a bit
    localparam logic [3:0] last_bit = 4'd10;                          // Stop bit index

    logic [cnt_w-1:0] clk_cnt;   // Clocks into current bit
    logic [3:0]       bit_cnt;   // Bit being driven, 0 is start
    logic [10:0]      frame_q;   // Bit 0 is on the line now
    logic             par_bit;   // Parity for the latched byte
    logic             start;     // Accepted send
    logic             bit_end;   // Current bit finishes this clock

    assign par_bit = (^data) ^ 1'(`LINK_PARITY_ODD);  // Even or odd per macro
    assign start   = send & ~busy;                    // Ignored while busy
    assign bit_end = busy & (clk_cnt == bit_last);

    // Frame shifter, bit 1 moves onto the line at each bit boundary
    always_ff @(posedge clk) begin
        if (start) begin
            frame_q <= {1'b1, par_bit, data, 1'b0};  // Stop, parity, data, start
        end else if (bit_end) begin
            frame_q <= {1'b1, frame_q[10:1]};        // Fill with idle level
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            tx      <= 1'b1;                         // Line idle
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            tx      <= 1'b0;                         // Start bit at this edge
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == last_bit) begin
                busy <= 1'b0;                        // Stop bit done
                tx   <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
                tx      <= frame_q[1];               // Next bit out
            end
        end else if (busy) begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

// File: vlog.f
+incdir+logic
logic/link_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/secded_codec.sv
logic/link_top.sv
dv/tb_clock.sv
dv/link_chk.sv
dv/link_tb.sv
